// ==== sim.f ====
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_control.sv
source/cpu_top.sv
verification/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu8086_core

sources:
  - source/cpu_pkg.sv
  - source/cpu_alu.sv
  - source/cpu_regfile.sv
  - source/cpu_control.sv
  - source/cpu_top.sv
  - target: simulation
    files:
      - verification/tb_cpu.sv

// ==== verification/cpu_golden.hex ====
// type address byte: 0 preloads memory, 1 expects a write, 2 ends a program
// Register ALU at 8 and 16 bits, AH as source and destination, CMP
0 0000 B0
0 0001 5A
0 0002 B4
0 0003 C3
0 0004 B1
0 0005 0F
0 0006 20
0 0007 C8
0 0008 00
0 0009 E0
0 000A 02
0 000B E1
0 000C 3D
0 000D 00
0 000E 00
0 000F 05
0 0010 34
0 0011 12
0 0012 38
0 0013 C8
0 0014 34
0 0015 FF
0 0016 89
0 0017 06
0 0018 00
0 0019 01
0 001A 88
0 001B 26
0 001C 02
0 001D 01
0 001E 70
0 001F FE
0 0020 71
0 0021 FC
1 0100 FE
1 0101 E5
1 0102 E5
2 0000 00
// Memory operands, carry with STC, CLC and INC
0 0000 BB
0 0001 00
0 0002 02
0 0003 BE
0 0004 10
0 0005 00
0 0006 03
0 0007 40
0 0008 F4
0 0009 01
0 000A 06
0 000B 00
0 000C 03
0 000D F9
0 000E 41
0 000F 11
0 0010 C8
0 0011 F8
0 0012 19
0 0013 C8
0 0014 89
0 0015 06
0 0016 02
0 0017 03
0 0018 70
0 0019 FE
0 001A 71
0 001B FC
0 0204 34
0 0205 12
0 0300 01
0 0301 01
1 0300 35
1 0301 13
1 0302 35
1 0303 12
2 0000 00
// Stack, then taken and not taken Jcc in both directions
0 0000 BC
0 0001 00
0 0002 08
0 0003 BA
0 0004 78
0 0005 56
0 0006 52
0 0007 5F
0 0008 89
0 0009 3E
0 000A 00
0 000B 01
0 000C 39
0 000D D2
0 000E 74
0 000F 04
0 0010 88
0 0011 36
0 0012 02
0 0013 01
0 0014 75
0 0015 04
0 0016 88
0 0017 16
0 0018 03
0 0019 01
0 001A 74
0 001B 08
0 001C 88
0 001D 16
0 001E 05
0 001F 01
0 0020 70
0 0021 FE
0 0022 71
0 0023 FC
0 0024 88
0 0025 36
0 0026 04
0 0027 01
0 0028 74
0 0029 F2
1 07FE 78
1 07FF 56
1 0100 78
1 0101 56
1 0103 78
1 0104 56
1 0105 78
2 0000 00

// ==== verification/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int SETTLE       = 16;     // Idle cycles to catch stray writes
    localparam int CYCLES_PER_BYTE = 40;

    logic        clock;
    logic        rst_n;
    logic [7:0]  rdata;
    logic [15:0] address;
    logic [7:0]  wdata;
    logic        we;

    logic [7:0]  mem [0:65535];

    // Records from the golden file
    int          rec_type [$];
    logic [15:0] rec_addr [$];
    logic [7:0]  rec_data [$];

    // Expected memory writes of the running program
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];

    int errors   = 0;
    int checks   = 0;
    int cycles   = 0;
    int limit    = 0;
    int programs = 0;

    assign rdata = mem[address];      // Combinational read

    cpu_top dut_i (
        .clock(clock),
        .i_rst_n(rst_n),
        .i_data(rdata),
        .o_address(address),
        .o_data(wdata),
        .o_we(we)
    );

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    always @(posedge clock) begin
        if (we)
            mem[address] <= wdata;
    end

    // ------------------------------------------------------------
    // Checks and helpers
    // ------------------------------------------------------------
    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic clear_memory();
        for (int i = 0; i < 65536; i++)
            mem[i] <= 8'h00;
    endtask

    task automatic read_golden();
        int          fd;
        int          code;
        int          t;
        logic [15:0] a;
        logic [7:0]  d;
        string       line;
        fd = $fopen("verification/cpu_golden.hex", "r");
        if (fd == 0) begin
            errors++;
            $display("The golden file could not be opened");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%h %h %h\n", t, a, d);
                if (code == 3) begin
                    rec_type.push_back(t);
                    rec_addr.push_back(a);
                    rec_data.push_back(d);
                    if (t == 0)
                        limit += CYCLES_PER_BYTE;
                end else begin
                    code = $fgets(line, fd);      // Comment line
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // Write stream monitor
    // ------------------------------------------------------------
    always @(negedge clock) begin
        if (we) begin                             // Outputs settle before the falling edge
            if (exp_addr.size() == 0) begin
                errors++;
                $display("Unexpected memory write at %0t ns: address %h, data %h",
                         $time, address, wdata);
            end else begin
                check("o_address", exp_addr.pop_front(), address);
                check("o_data", {8'h00, exp_data.pop_front()}, {8'h00, wdata});
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, %0d writes still expected",
                     cycles, exp_addr.size());
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int idx;
        rst_n = 1'b0;
        clear_memory();
        read_golden();
        idx = 0;
        while (idx < rec_type.size()) begin
            @(negedge clock);
            rst_n = 1'b0;
            @(negedge clock);
            clear_memory();
            exp_addr.delete();
            exp_data.delete();
            while (idx < rec_type.size() && rec_type[idx] != 2) begin
                if (rec_type[idx] == 0) begin
                    mem[rec_addr[idx]] <= rec_data[idx];
                end else begin
                    exp_addr.push_back(rec_addr[idx]);
                    exp_data.push_back(rec_data[idx]);
                end
                idx++;
            end
            idx++;                                // Skip the end marker
            repeat (RESET_CYCLES - 1) begin
                @(negedge clock);
                check("o_we", 16'h0000, {15'h0000, we});  // Strobe low in reset
            end
            rst_n = 1'b1;
            @(negedge clock);
            check("o_address", 16'h0000, address);  // First fetch at 0
            while (exp_addr.size() > 0)
                @(posedge clock);
            repeat (SETTLE) @(negedge clock);
            programs++;
        end

        $display("Programs: %0d, checks: %0d, errors: %0d", programs, checks, errors);
        if (errors == 0 && programs > 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                        clock,
    input  logic                        i_rst_n,
    input  logic [cpu_pkg::BYTE_W-1:0]  i_data,     // Memory content at o_address
    output logic [cpu_pkg::ADDR_W-1:0]  o_address,
    output logic [cpu_pkg::BYTE_W-1:0]  o_data,
    output logic                        o_we
);

    logic [cpu_pkg::WORD_W-1:0]  regs [cpu_pkg::REG_COUNT];
    logic [cpu_pkg::FLAGS_W-1:0] flags;
    logic                        wb;
    logic [2:0]                  wb_reg;
    logic                        wb_size;
    logic [cpu_pkg::WORD_W-1:0]  wb_data;
    logic                        wf;
    logic [cpu_pkg::FLAGS_W-1:0] wb_flags;
    logic [2:0]                  alu_op;
    logic                        size;
    logic [cpu_pkg::WORD_W-1:0]  op1;
    logic [cpu_pkg::WORD_W-1:0]  op2;
    logic [2:0]                  cond;
    logic [cpu_pkg::WORD_W:0]    alu_result;
    logic [cpu_pkg::FLAGS_W-1:0] alu_flags;
    logic                        cond_met;

    cpu_control control_i (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_mem_data(i_data), .o_mem_address(o_address), .o_mem_data(o_data), .o_mem_we(o_we),
        .i_regs(regs), .i_flags(flags),
        .o_wb(wb), .o_wb_reg(wb_reg), .o_wb_size(wb_size), .o_wb_data(wb_data),
        .o_wf(wf), .o_wb_flags(wb_flags),
        .o_alu_op(alu_op), .o_size(size), .o_op1(op1), .o_op2(op2), .o_cond(cond),
        .i_alu_result(alu_result), .i_alu_flags(alu_flags), .i_cond_met(cond_met)
    );

    cpu_regfile regfile_i (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_wb(wb), .i_wb_reg(wb_reg), .i_wb_size(wb_size), .i_wb_data(wb_data),
        .i_wf(wf), .i_wb_flags(wb_flags),
        .o_regs(regs), .o_flags(flags)
    );

    cpu_alu alu_i (
        .i_alu_op(alu_op), .i_size(size), .i_op1(op1), .i_op2(op2),
        .i_flags(flags), .i_cond(cond),
        .o_result(alu_result), .o_flags(alu_flags), .o_cond_met(cond_met)
    );

endmodule

// ==== source/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic                        clock,
    input  logic                        i_rst_n,
    input  logic [cpu_pkg::BYTE_W-1:0]  i_mem_data,
    output logic [cpu_pkg::ADDR_W-1:0]  o_mem_address,
    output logic [cpu_pkg::BYTE_W-1:0]  o_mem_data,
    output logic                        o_mem_we,
    input  logic [cpu_pkg::WORD_W-1:0]  i_regs [cpu_pkg::REG_COUNT],
    input  logic [cpu_pkg::FLAGS_W-1:0] i_flags,
    output logic                        o_wb,
    output logic [2:0]                  o_wb_reg,
    output logic                        o_wb_size,
    output logic [cpu_pkg::WORD_W-1:0]  o_wb_data,
    output logic                        o_wf,
    output logic [cpu_pkg::FLAGS_W-1:0] o_wb_flags,
    output logic [2:0]                  o_alu_op,
    output logic                        o_size,
    output logic [cpu_pkg::WORD_W-1:0]  o_op1,
    output logic [cpu_pkg::WORD_W-1:0]  o_op2,
    output logic [2:0]                  o_cond,
    input  logic [cpu_pkg::WORD_W:0]    i_alu_result,
    input  logic [cpu_pkg::FLAGS_W-1:0] i_alu_flags,
    input  logic                        i_cond_met
);

    logic [cpu_pkg::ADDR_W-1:0]  ip;
    logic [cpu_pkg::ADDR_W-1:0]  ea;
    logic [cpu_pkg::BYTE_W-1:0]  opcode;
    logic [cpu_pkg::BYTE_W-1:0]  modrm;
    logic [cpu_pkg::BYTE_W-1:0]  data_out;
    logic [cpu_pkg::WORD_W-1:0]  op1;
    logic [cpu_pkg::WORD_W-1:0]  op2;
    logic [cpu_pkg::WORD_W-1:0]  wb_data;
    logic [cpu_pkg::FLAGS_W-1:0] wb_flags;
    logic [2:0]                  state;
    logic [2:0]                  fnext;     // State after WBACK or a stack access
    logic [2:0]                  alu;
    logic [2:0]                  wb_reg;
    logic [2:0]                  s_modrm;
    logic [1:0]                  s_instr;
    logic [1:0]                  s_wback;
    logic [1:0]                  s_stack;
    logic                        dir;       // 1 when reg is the destination
    logic                        size;      // 1 for word
    logic                        bus;       // Address from ea
    logic                        we;
    logic                        wb;
    logic                        wf;

    // Source register at byte or word width, bytes zero extended
    function automatic logic [cpu_pkg::WORD_W-1:0] src_reg(input logic [2:0] idx,
                                                           input logic wide);
        cpu_pkg::reg_word_u r;
        r.word = i_regs[wide ? idx : {1'b0, idx[1:0]}];
        if (wide)
            return r.word;
        return {8'h00, idx[2] ? r.bytes.hi : r.bytes.lo};
    endfunction

    assign o_mem_address = bus ? ea : ip;
    assign o_mem_data    = data_out;
    assign o_mem_we      = we;
    assign o_wb          = wb;
    assign o_wb_reg      = wb_reg;
    assign o_wb_size     = size;
    assign o_wb_data     = wb_data;
    assign o_wf          = wf;
    assign o_wb_flags    = wb_flags;
    assign o_alu_op      = alu;
    assign o_size        = size;
    assign o_op1         = op1;
    assign o_op2         = op2;
    assign o_cond        = opcode[3:1];

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state   <= cpu_pkg::ST_START;
            fnext   <= cpu_pkg::ST_START;
            ip      <= '0;
            bus     <= 1'b0;
            we      <= 1'b0;
            wb      <= 1'b0;
            wf      <= 1'b0;
            s_modrm <= '0;
            s_instr <= '0;
            s_wback <= '0;
            s_stack <= '0;
        end else begin
            wb <= 1'b0;
            wf <= 1'b0;
            case (state)
                // ------------------------------------------------------------
                cpu_pkg::ST_START: begin
                    state   <= cpu_pkg::ST_LOAD;
                    fnext   <= cpu_pkg::ST_START;
                    bus     <= 1'b0;
                    we      <= 1'b0;
                    s_modrm <= '0;
                    s_instr <= '0;
                    s_wback <= '0;
                    s_stack <= '0;
                end
                // Opcode fetch and decode ------------------------------------
                cpu_pkg::ST_LOAD: begin
                    opcode <= i_mem_data;
                    size   <= i_mem_data[0];
                    dir    <= i_mem_data[1];
                    alu    <= i_mem_data[5:3];
                    ip     <= ip + 1'b1;
                    casez (i_mem_data)
                        8'b00???0??,
                        8'b100010??: state <= cpu_pkg::ST_MODRM;  // ALU rm and MOV rm
                        8'b00???10?,
                        8'b0111????,
                        8'b1011????: state <= cpu_pkg::ST_INSTR;  // Immediate forms and Jcc
                        8'b0100????: begin                        // INC and DEC r16
                            state <= cpu_pkg::ST_INSTR;
                            alu   <= i_mem_data[3] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                            op1   <= i_regs[i_mem_data[2:0]];
                            op2   <= 16'd1;
                            size  <= 1'b1;
                        end
                        8'b01010???: begin
                            state   <= cpu_pkg::ST_PUSH;
                            wb_data <= i_regs[i_mem_data[2:0]];
                        end
                        8'b01011???: begin
                            state <= cpu_pkg::ST_POP;
                            fnext <= cpu_pkg::ST_INSTR;           // Register write after pop
                        end
                        8'b1111100?,
                        8'b1111101?,
                        8'b1111110?: begin                        // CLx and STx
                            state    <= cpu_pkg::ST_START;
                            wf       <= 1'b1;
                            wb_flags <= i_flags;
                            case (i_mem_data[2:1])
                                2'b00:   wb_flags[cpu_pkg::CF] <= i_mem_data[0];
                                2'b01:   wb_flags[cpu_pkg::IF] <= i_mem_data[0];
                                default: wb_flags[cpu_pkg::DF] <= i_mem_data[0];
                            endcase
                        end
                        default: state <= cpu_pkg::ST_START;      // Unsupported opcode skipped
                    endcase
                end
                // ModRM, displacement and memory operand ---------------------
                cpu_pkg::ST_MODRM: case (s_modrm)
                    3'd0: begin
                        modrm <= i_mem_data;
                        ip    <= ip + 1'b1;
                        op1   <= src_reg(dir ? i_mem_data[5:3] : i_mem_data[2:0], size);
                        op2   <= src_reg(dir ? i_mem_data[2:0] : i_mem_data[5:3], size);
                        case (i_mem_data[2:0])
                            3'd0: ea <= i_regs[cpu_pkg::REG_BX] + i_regs[cpu_pkg::REG_SI];
                            3'd1: ea <= i_regs[cpu_pkg::REG_BX] + i_regs[cpu_pkg::REG_DI];
                            3'd2: ea <= i_regs[cpu_pkg::REG_BP] + i_regs[cpu_pkg::REG_SI];
                            3'd3: ea <= i_regs[cpu_pkg::REG_BP] + i_regs[cpu_pkg::REG_DI];
                            3'd4: ea <= i_regs[cpu_pkg::REG_SI];
                            3'd5: ea <= i_regs[cpu_pkg::REG_DI];
                            3'd6: ea <= (i_mem_data[7:6] == 2'b00) ? '0 : i_regs[cpu_pkg::REG_BP];
                            3'd7: ea <= i_regs[cpu_pkg::REG_BX];
                        endcase
                        casez (i_mem_data)
                            8'b00???110: s_modrm <= 3'd2;         // Direct disp16
                            8'b00??????: begin
                                s_modrm <= 3'd4;
                                bus     <= 1'b1;
                            end
                            8'b01??????: s_modrm <= 3'd1;
                            8'b10??????: s_modrm <= 3'd2;
                            default:     state   <= cpu_pkg::ST_INSTR;  // Register operand
                        endcase
                    end
                    3'd1: begin                                   // disp8 sign extended
                        s_modrm <= 3'd4;
                        ip      <= ip + 1'b1;
                        ea      <= ea + {{8{i_mem_data[7]}}, i_mem_data};
                        bus     <= 1'b1;
                    end
                    3'd2: begin
                        s_modrm <= 3'd3;
                        ip      <= ip + 1'b1;
                        ea      <= ea + {8'h00, i_mem_data};
                    end
                    3'd3: begin
                        s_modrm    <= 3'd4;
                        ip         <= ip + 1'b1;
                        ea[15:8]   <= ea[15:8] + i_mem_data;
                        bus        <= 1'b1;
                    end
                    3'd4: begin                                   // Low byte of operand
                        if (dir)
                            op2 <= {8'h00, i_mem_data};
                        else
                            op1 <= {8'h00, i_mem_data};
                        if (size) begin
                            s_modrm <= 3'd5;
                            ea      <= ea + 1'b1;
                        end else begin
                            state <= cpu_pkg::ST_INSTR;
                        end
                    end
                    default: begin
                        if (dir)
                            op2[15:8] <= i_mem_data;
                        else
                            op1[15:8] <= i_mem_data;
                        ea    <= ea - 1'b1;                       // Back to the low byte
                        state <= cpu_pkg::ST_INSTR;
                    end
                endcase
                // Execute ----------------------------------------------------
                cpu_pkg::ST_INSTR: casez (opcode)
                    8'b00???0??: begin
                        wb_data  <= i_alu_result[15:0];
                        wb_flags <= i_alu_flags;
                        wf       <= 1'b1;
                        state    <= (alu != cpu_pkg::ALU_CMP) ? cpu_pkg::ST_WBACK
                                                              : cpu_pkg::ST_START;
                    end
                    8'b00???10?: case (s_instr)                   // ALU with AL or AX
                        2'd0: begin
                            op1     <= src_reg(cpu_pkg::REG_AX, size);
                            op2     <= {8'h00, i_mem_data};
                            ip      <= ip + 1'b1;
                            s_instr <= size ? 2'd1 : 2'd2;
                        end
                        2'd1: begin
                            op2[15:8] <= i_mem_data;
                            ip        <= ip + 1'b1;
                            s_instr   <= 2'd2;
                        end
                        default: begin
                            wb_data  <= i_alu_result[15:0];
                            wb_flags <= i_alu_flags;
                            wb_reg   <= cpu_pkg::REG_AX;
                            wb       <= (alu != cpu_pkg::ALU_CMP);
                            wf       <= 1'b1;
                            state    <= cpu_pkg::ST_START;
                        end
                    endcase
                    8'b1011????: begin                            // MOV r with immediate
                        ip <= ip + 1'b1;
                        if (s_instr == 2'd0) begin
                            wb_data <= {8'h00, i_mem_data};
                            wb_reg  <= opcode[2:0];
                            wb      <= ~opcode[3];
                            size    <= opcode[3];
                            s_instr <= 2'd1;
                            if (!opcode[3])
                                state <= cpu_pkg::ST_START;
                        end else begin
                            wb_data[15:8] <= i_mem_data;
                            wb            <= 1'b1;
                            state         <= cpu_pkg::ST_START;
                        end
                    end
                    8'b100010??: begin
                        wb_data <= op2;
                        state   <= cpu_pkg::ST_WBACK;
                    end
                    8'b0111????: begin                            // Jcc with low bit inverting
                        if (i_cond_met ^ opcode[0])
                            ip <= ip + 1'b1 + {{8{i_mem_data[7]}}, i_mem_data};
                        else
                            ip <= ip + 1'b1;
                        state <= cpu_pkg::ST_START;
                    end
                    8'b0100????: begin
                        wb_data               <= i_alu_result[15:0];
                        wb_flags              <= i_alu_flags;
                        wb_flags[cpu_pkg::CF] <= i_flags[cpu_pkg::CF];  // CF untouched
                        wb_reg                <= opcode[2:0];
                        wb                    <= 1'b1;
                        wf                    <= 1'b1;
                        state                 <= cpu_pkg::ST_START;
                    end
                    8'b01011???: begin                            // Value already in wb_data
                        wb_reg <= opcode[2:0];
                        wb     <= 1'b1;
                        state  <= cpu_pkg::ST_START;
                    end
                    default: state <= cpu_pkg::ST_START;
                endcase
                // Result to register or memory -------------------------------
                cpu_pkg::ST_WBACK: case (s_wback)
                    2'd0: begin
                        if (dir || modrm[7:6] == 2'b11) begin
                            wb_reg <= dir ? modrm[5:3] : modrm[2:0];
                            wb     <= 1'b1;
                            bus    <= 1'b0;
                            state  <= fnext;
                        end else begin
                            data_out <= wb_data[7:0];
                            we       <= 1'b1;
                            s_wback  <= 2'd1;
                        end
                    end
                    2'd1: begin
                        if (size) begin
                            ea       <= ea + 1'b1;
                            data_out <= wb_data[15:8];
                            s_wback  <= 2'd2;
                        end else begin
                            we    <= 1'b0;
                            bus   <= 1'b0;
                            state <= fnext;
                        end
                    end
                    default: begin
                        we    <= 1'b0;
                        bus   <= 1'b0;
                        state <= fnext;
                    end
                endcase
                // Stack ------------------------------------------------------
                cpu_pkg::ST_PUSH: case (s_stack)
                    2'd0: begin
                        ea       <= i_regs[cpu_pkg::REG_SP] - 16'd2;
                        bus      <= 1'b1;
                        data_out <= wb_data[7:0];
                        we       <= 1'b1;
                        s_stack  <= 2'd1;
                    end
                    2'd1: begin
                        ea       <= ea + 1'b1;
                        data_out <= wb_data[15:8];
                        wb_data  <= i_regs[cpu_pkg::REG_SP] - 16'd2;  // New SP
                        wb_reg   <= cpu_pkg::REG_SP;
                        wb       <= 1'b1;
                        size     <= 1'b1;
                        s_stack  <= 2'd2;
                    end
                    default: begin
                        we      <= 1'b0;
                        bus     <= 1'b0;
                        s_stack <= 2'd0;
                        state   <= fnext;
                    end
                endcase
                cpu_pkg::ST_POP: case (s_stack)
                    2'd0: begin
                        ea      <= i_regs[cpu_pkg::REG_SP];
                        bus     <= 1'b1;
                        wb_data <= i_regs[cpu_pkg::REG_SP] + 16'd2;
                        wb_reg  <= cpu_pkg::REG_SP;
                        wb      <= 1'b1;
                        size    <= 1'b1;
                        s_stack <= 2'd1;
                    end
                    2'd1: begin
                        wb_data[7:0] <= i_mem_data;
                        ea           <= ea + 1'b1;
                        s_stack      <= 2'd2;
                    end
                    default: begin
                        wb_data[15:8] <= i_mem_data;
                        bus           <= 1'b0;
                        s_stack       <= 2'd0;
                        state         <= fnext;
                    end
                endcase
                default: state <= cpu_pkg::ST_START;
            endcase
        end
    end

endmodule

// ==== source/cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile (
    input  logic                        clock,
    input  logic                        i_rst_n,
    input  logic                        i_wb,
    input  logic [2:0]                  i_wb_reg,
    input  logic                        i_wb_size,
    input  logic [cpu_pkg::WORD_W-1:0]  i_wb_data,
    input  logic                        i_wf,
    input  logic [cpu_pkg::FLAGS_W-1:0] i_wb_flags,
    output logic [cpu_pkg::WORD_W-1:0]  o_regs [cpu_pkg::REG_COUNT],
    output logic [cpu_pkg::FLAGS_W-1:0] o_flags
);

    logic [2:0]         target;     // Byte writes land in AX to BX
    cpu_pkg::reg_word_u merged;

    assign target = i_wb_size ? i_wb_reg : {1'b0, i_wb_reg[1:0]};

    // Merge a byte into the current word
    always_comb begin
        merged.word = o_regs[target];
        if (i_wb_size)
            merged.word = i_wb_data;
        else if (i_wb_reg[2])
            merged.bytes.hi = i_wb_data[7:0];
        else
            merged.bytes.lo = i_wb_data[7:0];
    end

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++)
                o_regs[i] <= '0;
            o_flags <= '0;
        end else begin
            if (i_wb)
                o_regs[target] <= merged.word;
            if (i_wf)
                o_flags <= i_wb_flags;
        end
    end

endmodule

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
    input  logic [2:0]                  i_alu_op,
    input  logic                        i_size,
    input  logic [cpu_pkg::WORD_W-1:0]  i_op1,
    input  logic [cpu_pkg::WORD_W-1:0]  i_op2,
    input  logic [cpu_pkg::FLAGS_W-1:0] i_flags,
    input  logic [2:0]                  i_cond,
    output logic [cpu_pkg::WORD_W:0]    o_result,   // Carry in the top bit
    output logic [cpu_pkg::FLAGS_W-1:0] o_flags,
    output logic                        o_cond_met
);

    logic [cpu_pkg::WORD_W:0] a;
    logic [cpu_pkg::WORD_W:0] b;
    logic [cpu_pkg::WORD_W:0] cin;
    logic                     sign_a;
    logic                     sign_b;
    logic                     sign_r;
    logic [7:0]               conds;

    assign a      = {1'b0, i_op1};
    assign b      = {1'b0, i_op2};
    assign cin    = {16'h0000, i_flags[cpu_pkg::CF]};
    assign sign_a = i_size ? i_op1[15] : i_op1[7];
    assign sign_b = i_size ? i_op2[15] : i_op2[7];
    assign sign_r = i_size ? o_result[15] : o_result[7];

    always_comb begin
        case (i_alu_op)
            cpu_pkg::ALU_ADD: o_result = a + b;
            cpu_pkg::ALU_OR:  o_result = a | b;
            cpu_pkg::ALU_ADC: o_result = a + b + cin;
            cpu_pkg::ALU_SBB: o_result = a - b - cin;
            cpu_pkg::ALU_AND: o_result = a & b;
            cpu_pkg::ALU_XOR: o_result = a ^ b;
            default:          o_result = a - b;           // SUB and CMP
        endcase
    end

    // ------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------
    always_comb begin
        o_flags = i_flags;
        o_flags[cpu_pkg::CF] = i_size ? o_result[16] : o_result[8];
        o_flags[cpu_pkg::AF] = i_op1[4] ^ i_op2[4] ^ o_result[4];
        case (i_alu_op)
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_ADC: o_flags[cpu_pkg::OF] = ~(sign_a ^ sign_b) & (sign_a ^ sign_r);
            cpu_pkg::ALU_SUB,
            cpu_pkg::ALU_SBB,
            cpu_pkg::ALU_CMP: o_flags[cpu_pkg::OF] = (sign_a ^ sign_b) & (sign_a ^ sign_r);
            default: begin
                o_flags[cpu_pkg::OF] = 1'b0;              // Logic ops clear OF and CF
                o_flags[cpu_pkg::CF] = 1'b0;
                o_flags[cpu_pkg::AF] = 1'b0;
            end
        endcase
        o_flags[cpu_pkg::SF] = sign_r;
        o_flags[cpu_pkg::ZF] = i_size ? (o_result[15:0] == '0) : (o_result[7:0] == '0);
        o_flags[cpu_pkg::PF] = ~^o_result[7:0];
    end

    // Jcc base conditions by opcode bits 3:1
    assign conds = {
        (i_flags[cpu_pkg::SF] ^ i_flags[cpu_pkg::OF]) | i_flags[cpu_pkg::ZF],  // LE
        i_flags[cpu_pkg::SF] ^ i_flags[cpu_pkg::OF],                           // L
        i_flags[cpu_pkg::PF],
        i_flags[cpu_pkg::SF],
        i_flags[cpu_pkg::CF] | i_flags[cpu_pkg::ZF],                           // BE
        i_flags[cpu_pkg::ZF],
        i_flags[cpu_pkg::CF],
        i_flags[cpu_pkg::OF]
    };
    assign o_cond_met = conds[i_cond];

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int WORD_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int ADDR_W    = 16;
    localparam int FLAGS_W   = 12;
    localparam int REG_COUNT = 8;

    // Register indices as encoded in the opcode and ModRM
    localparam logic [2:0] REG_AX = 3'd0;
    localparam logic [2:0] REG_CX = 3'd1;
    localparam logic [2:0] REG_DX = 3'd2;
    localparam logic [2:0] REG_BX = 3'd3;
    localparam logic [2:0] REG_SP = 3'd4;
    localparam logic [2:0] REG_BP = 3'd5;
    localparam logic [2:0] REG_SI = 3'd6;
    localparam logic [2:0] REG_DI = 3'd7;

    // Flag bit positions
    localparam int CF = 0;
    localparam int PF = 2;
    localparam int AF = 4;
    localparam int ZF = 6;
    localparam int SF = 7;
    localparam int IF = 9;
    localparam int DF = 10;
    localparam int OF = 11;

    // ALU codes follow opcode bits 5:3
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_OR  = 3'd1;
    localparam logic [2:0] ALU_ADC = 3'd2;
    localparam logic [2:0] ALU_SBB = 3'd3;
    localparam logic [2:0] ALU_AND = 3'd4;
    localparam logic [2:0] ALU_SUB = 3'd5;
    localparam logic [2:0] ALU_XOR = 3'd6;
    localparam logic [2:0] ALU_CMP = 3'd7;

    // Sequencer states
    localparam logic [2:0] ST_START = 3'd0;
    localparam logic [2:0] ST_LOAD  = 3'd1;
    localparam logic [2:0] ST_MODRM = 3'd2;
    localparam logic [2:0] ST_INSTR = 3'd3;
    localparam logic [2:0] ST_WBACK = 3'd4;
    localparam logic [2:0] ST_PUSH  = 3'd5;
    localparam logic [2:0] ST_POP   = 3'd6;

    // ------------------------------------------------------------
    // Register word seen whole or as two bytes
    // ------------------------------------------------------------
    typedef struct packed {
        logic [BYTE_W-1:0] hi;
        logic [BYTE_W-1:0] lo;
    } reg_bytes_t;

    typedef union packed {
        logic [WORD_W-1:0] word;
        reg_bytes_t        bytes;
    } reg_word_u;

endpackage
